//--- src/syncPkg.sv
// Loop types and constants
package syncPkg;

    // DAC word and scaling
    localparam int dacWidth = 16;
    localparam int scaleShift = 8;

    // Control updates needed before lock is declared
    localparam int unlockCount = 20;

    typedef logic signed [dacWidth-1:0] dacValue_t;
    typedef logic signed [dacWidth+scaleShift-1:0] dacScaled_t;

    // Phase error in clock ticks
    typedef logic signed [23:0] phaseError_t;

    typedef enum logic [2:0] {
        initialize,
        awaitHwPps,
        awaitLateHwPps,
        computeAction,
        awaitMultiply,
        awaitAccumulate,
        applyDelta,
        awaitDacIdle
    } pllState_t;

endpackage

//--- src/csrPkg.sv
// Register port words
package csrPkg;

    // Command word, disable request wins over enable
    typedef struct packed {
        logic pllEnable;
        logic pllDisable;
        logic dacLoad;
        logic [12:0] reserved;
        syncPkg::dacValue_t dacValue;
    } csrCommand_t;

    // Status readback
    typedef struct packed {
        logic locked;
        logic enabled;
        logic hwPpsValid;
        logic primaryValid;
        logic secondaryValid;
        syncPkg::pllState_t pllState;
        syncPkg::phaseError_t phaseError;
    } syncStatus_t;

endpackage

//--- src/ppsQualifier.sv
// PPS input qualifier
`timescale 1ns/100ps

module ppsQualifier #(
    parameter int clkRate = 100_000_000,
    parameter int debounceTicks = 200,
    parameter int toleranceTicks = 20_000
) (
    input  logic clk,
    input  logic rstN,
    input  logic ppsAsync,
    output logic ppsStrobe,
    output logic ppsValid
);

    // Interval window, too fast below and too slow above
    localparam int fastReload = clkRate - toleranceTicks - 1;
    localparam int slowReload = clkRate + toleranceTicks;
    localparam int intervalWidth = $clog2(slowReload + 1);
    localparam int debounceWidth = $clog2(debounceTicks + 1);

    logic ppsMeta;
    logic ppsSync;
    logic ppsDelayed;
    logic [debounceWidth-1:0] debounceCount;
    logic [intervalWidth-1:0] tooFastCount;
    logic [intervalWidth-1:0] tooSlowCount;
    logic risingEdge;
    logic debounceDone;
    logic tooFast;
    logic tooSlow;

    assign risingEdge = ppsSync && !ppsDelayed;
    assign debounceDone = (debounceCount == '0);
    assign tooFast = (tooFastCount != '0);
    assign tooSlow = (tooSlowCount == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ppsMeta <= 1'b0;
            ppsSync <= 1'b0;
            ppsDelayed <= 1'b0;
            debounceCount <= debounceWidth'(debounceTicks);
            tooFastCount <= '0;
            tooSlowCount <= '0;
            ppsStrobe <= 1'b0;
            ppsValid <= 1'b0;
        end else begin
            ppsMeta <= ppsAsync;
            ppsSync <= ppsMeta;
            ppsDelayed <= ppsSync;
            ppsStrobe <= 1'b0;

            // Count low cycles before an edge is accepted
            if (ppsSync) begin
                debounceCount <= debounceWidth'(debounceTicks);
            end else if (!debounceDone) begin
                debounceCount <= debounceCount - 1'b1;
            end

            if (risingEdge && debounceDone) begin
                if (!tooFast && !tooSlow) begin
                    ppsStrobe <= 1'b1;
                    ppsValid <= 1'b1;
                end else begin
                    ppsValid <= 1'b0;
                end
                tooFastCount <= intervalWidth'(fastReload);
                tooSlowCount <= intervalWidth'(slowReload);
            end else begin
                if (tooFast) begin
                    tooFastCount <= tooFastCount - 1'b1;
                end
                // Timeout when no edge arrives
                if (tooSlow) begin
                    ppsValid <= 1'b0;
                end else begin
                    tooSlowCount <= tooSlowCount - 1'b1;
                end
            end
        end
    end

endmodule

//--- src/localPpsGen.sv
// Local PPS generator
`timescale 1ns/100ps

module localPpsGen #(
    parameter int clkRate = 100_000_000
) (
    input  logic clk,
    input  logic rstN,
    input  logic hwStrobe,
    input  logic followHw,
    output logic ppsStrobe
);

    // Following reload is one short, the pulse already lags hwStrobe by one
    localparam int freeReload = clkRate - 1;
    localparam int followReload = clkRate - 2;
    localparam int countWidth = $clog2(clkRate);

    logic [countWidth-1:0] count;
    logic fire;

    assign fire = followHw ? hwStrobe : (count == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= countWidth'(freeReload);
            ppsStrobe <= 1'b0;
        end else begin
            ppsStrobe <= fire;
            if (fire) begin
                count <= followHw ? countWidth'(followReload) : countWidth'(freeReload);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/csrRegs.sv
// Command register decode
`timescale 1ns/100ps

module csrRegs (
    input  logic clk,
    input  logic rstN,
    input  logic csrStrobe,
    input  csrPkg::csrCommand_t command,
    output logic pllEnable,
    output logic dacLoad,
    output syncPkg::dacValue_t dacLoadValue
);

    // Enable level and load pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pllEnable <= 1'b0;
            dacLoad <= 1'b0;
        end else begin
            dacLoad <= csrStrobe && command.dacLoad;
            if (csrStrobe) begin
                if (command.pllDisable) begin
                    pllEnable <= 1'b0;
                end else if (command.pllEnable) begin
                    pllEnable <= 1'b1;
                end
            end
        end
    end

    // Manual DAC value
    always_ff @(posedge clk) begin
        if (csrStrobe && command.dacLoad) begin
            dacLoadValue <= command.dacValue;
        end
    end

endmodule

//--- src/pllController.sv
// PPS phase-locked loop controller
`timescale 1ns/100ps

module pllController #(
    parameter int detectRange = 3_000,
    parameter int dacCountsPerHz = 35
) (
    input  logic clk,
    input  logic rstN,
    input  logic pllEnable,
    input  logic dacLoad,
    input  logic hwPpsValid,
    input  logic hwStrobe,
    input  logic ppsStrobe,
    input  logic dacBusy,
    input  syncPkg::dacValue_t dacLoadValue,
    output logic followHw,
    output logic locked,
    output logic dacStrobe,
    output syncPkg::dacValue_t dacValue,
    output syncPkg::phaseError_t phaseError,
    output syncPkg::pllState_t pllState
);
    import syncPkg::*;

    localparam int gateWidth = $clog2(detectRange + 1);
    localparam int unlockWidth = $clog2(unlockCount + 1);
    localparam int wideWidth = $bits(phaseError_t) + $clog2(dacCountsPerHz + 1) + 2;

    // Gains as shifts, fast Kp 1/2 Ki 1/4, slow Kp 1/16 Ki 1/256
    localparam int fastKpShift = scaleShift - 1;
    localparam int fastKiShift = scaleShift - 2;
    localparam int slowKpShift = scaleShift - 4;
    localparam int slowKiShift = scaleShift - 8;

    localparam logic signed [wideWidth-1:0] countsPerHz = wideWidth'(dacCountsPerHz);
    localparam logic signed [wideWidth-1:0] scaledMax =
        (2 ** (dacWidth - 1) - 1) * (2 ** scaleShift);
    localparam logic signed [wideWidth-1:0] scaledMin =
        -(2 ** (dacWidth - 1)) * (2 ** scaleShift);

    logic [gateWidth-1:0] earlyCount;
    logic [gateWidth-1:0] lateCount;
    logic [unlockWidth-1:0] unlockCounter;
    logic earlyOverflow;
    logic lateOverflow;
    phaseError_t phaseErrorOld;
    phaseError_t errorStep;
    phaseError_t hzDelta;
    logic signed [wideWidth-1:0] dacDelta;
    logic signed [wideWidth-1:0] nextScaled;
    dacScaled_t dacScaled;

    assign earlyOverflow = (earlyCount == gateWidth'(detectRange));
    assign lateOverflow = (lateCount == gateWidth'(detectRange));
    assign errorStep = phaseError - phaseErrorOld;
    assign locked = (unlockCounter == '0);
    assign followHw = (pllState == initialize);
    assign dacValue = dacScaled[scaleShift +: dacWidth];

    //////////////////////////////
    // Velocity form PI, scaling and accumulate
    always_ff @(posedge clk) begin
        if (pllState == computeAction) begin
            if (locked) begin
                hzDelta <= (errorStep <<< slowKpShift) + (phaseError <<< slowKiShift);
            end else begin
                hzDelta <= (errorStep <<< fastKpShift) + (phaseError <<< fastKiShift);
            end
        end
        if (pllState == awaitMultiply) begin
            dacDelta <= hzDelta * countsPerHz;
        end
        if (pllState == awaitAccumulate) begin
            nextScaled <= dacDelta + dacScaled;
        end
    end

    //////////////////////////////
    // Loop state machine
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pllState <= initialize;
            phaseError <= '0;
            phaseErrorOld <= '0;
            earlyCount <= gateWidth'(detectRange);
            lateCount <= '0;
            unlockCounter <= unlockWidth'(unlockCount);
            dacScaled <= '0;
            dacStrobe <= 1'b0;
        end else begin
            dacStrobe <= 1'b0;
            case (pllState)
                initialize: begin
                    phaseError <= '0;
                    phaseErrorOld <= '0;
                    earlyCount <= gateWidth'(detectRange);
                    unlockCounter <= unlockWidth'(unlockCount);
                    if (pllEnable && hwPpsValid && hwStrobe) begin
                        pllState <= awaitHwPps;
                    end else if (dacLoad) begin
                        dacScaled <= {dacLoadValue, {scaleShift{1'b0}}};
                        dacStrobe <= 1'b1;
                    end
                end
                awaitHwPps: begin
                    lateCount <= gateWidth'(1);
                    // Ticks since the local pulse
                    if (ppsStrobe) begin
                        earlyCount <= gateWidth'(1);
                    end else if (!earlyOverflow) begin
                        earlyCount <= earlyCount + 1'b1;
                    end
                    if (!pllEnable || !hwPpsValid) begin
                        pllState <= initialize;
                    end else if (hwStrobe) begin
                        if (ppsStrobe) begin
                            phaseError <= '0;
                            pllState <= computeAction;
                        end else if (!earlyOverflow) begin
                            phaseError <= -phaseError_t'(earlyCount);
                            pllState <= computeAction;
                        end else begin
                            pllState <= awaitLateHwPps;
                        end
                    end
                end
                awaitLateHwPps: begin
                    lateCount <= lateCount + 1'b1;
                    if (!pllEnable || !hwPpsValid) begin
                        pllState <= initialize;
                    end else if (ppsStrobe) begin
                        phaseError <= phaseError_t'(lateCount);
                        pllState <= computeAction;
                    end else if (lateOverflow) begin
                        // Local pulse missing from the window
                        pllState <= initialize;
                    end
                end
                computeAction: begin
                    phaseErrorOld <= phaseError;
                    earlyCount <= gateWidth'(detectRange);
                    pllState <= awaitMultiply;
                end
                awaitMultiply: begin
                    pllState <= awaitAccumulate;
                end
                awaitAccumulate: begin
                    pllState <= applyDelta;
                end
                applyDelta: begin
                    // Saturate at the DAC limits
                    if (nextScaled > scaledMax) begin
                        dacScaled <= dacScaled_t'(scaledMax);
                    end else if (nextScaled < scaledMin) begin
                        dacScaled <= dacScaled_t'(scaledMin);
                    end else begin
                        dacScaled <= dacScaled_t'(nextScaled);
                    end
                    if (!locked) begin
                        unlockCounter <= unlockCounter - 1'b1;
                    end
                    dacStrobe <= 1'b1;
                    pllState <= awaitDacIdle;
                end
                awaitDacIdle: begin
                    if (!dacStrobe && !dacBusy) begin
                        pllState <= awaitHwPps;
                    end
                end
                default: begin
                    pllState <= initialize;
                end
            endcase
        end
    end

endmodule

//--- src/dacSpiWriter.sv
// DAC serial writer
`timescale 1ns/100ps

module dacSpiWriter #(
    parameter int spiHalfTicks = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic dacStrobe,
    input  logic offsetBinary,
    input  syncPkg::dacValue_t dacValue,
    output logic SPI_CLK,
    output logic SPI_SYNCn,
    output logic SPI_SDI,
    output logic dacBusy
);
    import syncPkg::*;

    localparam int frameWidth = 24;
    localparam int halfWidth = $clog2(spiHalfTicks + 2);
    localparam int bitWidth = $clog2(frameWidth + 1);

    typedef enum logic [1:0] {
        spiIdle,
        spiTransfer,
        spiFinish
    } spiState_t;

    spiState_t spiState;
    logic [halfWidth-1:0] halfCount;
    logic [bitWidth-1:0] bitCount;
    logic [frameWidth-1:0] shiftReg;
    dacValue_t sendValue;
    logic halfDone;

    // Offset binary flips the sign bit
    assign sendValue = dacValue ^ {offsetBinary, {(dacWidth - 1){1'b0}}};
    assign halfDone = (halfCount == '0);
    assign SPI_SDI = shiftReg[frameWidth-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            spiState <= spiIdle;
            halfCount <= halfWidth'(spiHalfTicks);
            bitCount <= '0;
            shiftReg <= '0;
            SPI_CLK <= 1'b1;
            SPI_SYNCn <= 1'b1;
            dacBusy <= 1'b0;
        end else begin
            // Half-period timer
            if ((spiState == spiIdle) || halfDone) begin
                halfCount <= halfWidth'(spiHalfTicks);
            end else begin
                halfCount <= halfCount - 1'b1;
            end

            case (spiState)
                spiIdle: begin
                    bitCount <= bitWidth'(frameWidth);
                    if (dacStrobe) begin
                        dacBusy <= 1'b1;
                        SPI_SYNCn <= 1'b0;
                        shiftReg <= {{(frameWidth - dacWidth){1'b0}}, sendValue};
                        spiState <= spiTransfer;
                    end
                end
                spiTransfer: begin
                    if (halfDone) begin
                        if (SPI_CLK) begin
                            if (bitCount == '0) begin
                                SPI_SYNCn <= 1'b1;
                                spiState <= spiFinish;
                            end else begin
                                // DAC samples on this falling edge
                                SPI_CLK <= 1'b0;
                                bitCount <= bitCount - 1'b1;
                            end
                        end else begin
                            SPI_CLK <= 1'b1;
                            shiftReg <= shiftReg << 1;
                        end
                    end
                end
                spiFinish: begin
                    if (halfDone) begin
                        dacBusy <= 1'b0;
                        spiState <= spiIdle;
                    end
                end
                default: begin
                    spiState <= spiIdle;
                end
            endcase
        end
    end

endmodule

//--- src/clockSyncTop.sv
// VCXO to PPS synchronizer
`timescale 1ns/100ps

module clockSyncTop #(
    parameter int clkRate = 100_000_000,
    parameter int debounceTicks = 200,
    parameter int toleranceTicks = 20_000,
    parameter int detectRange = 3_000,
    parameter int dacCountsPerHz = 35,
    parameter int spiHalfTicks = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic csrStrobe,
    input  logic ppsPrimary,
    input  logic ppsSecondary,
    input  logic offsetBinary,
    input  csrPkg::csrCommand_t command,
    output csrPkg::syncStatus_t status,
    output syncPkg::dacValue_t dacReadback,
    output logic ppsStrobe,
    output logic SPI_CLK,
    output logic SPI_SYNCn,
    output logic SPI_SDI
);
    import syncPkg::*;

    logic primaryStrobe;
    logic primaryValid;
    logic secondaryStrobe;
    logic secondaryValid;
    logic hwStrobe;
    logic hwPpsValid;
    logic pllEnable;
    logic dacLoad;
    dacValue_t dacLoadValue;
    logic followHw;
    logic locked;
    logic dacStrobe;
    logic dacBusy;
    dacValue_t dacValue;
    phaseError_t phaseError;
    pllState_t pllState;

    //////////////////////////////
    // Reference qualification and selection
    ppsQualifier #(
        .clkRate(clkRate),
        .debounceTicks(debounceTicks),
        .toleranceTicks(toleranceTicks)
    ) u_primaryQualifier (
        .clk(clk),
        .rstN(rstN),
        .ppsAsync(ppsPrimary),
        .ppsStrobe(primaryStrobe),
        .ppsValid(primaryValid)
    );

    ppsQualifier #(
        .clkRate(clkRate),
        .debounceTicks(debounceTicks),
        .toleranceTicks(toleranceTicks)
    ) u_secondaryQualifier (
        .clk(clk),
        .rstN(rstN),
        .ppsAsync(ppsSecondary),
        .ppsStrobe(secondaryStrobe),
        .ppsValid(secondaryValid)
    );

    // Primary wins whenever it is valid
    assign hwStrobe = primaryValid ? primaryStrobe : secondaryStrobe;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hwPpsValid <= 1'b0;
        end else begin
            hwPpsValid <= primaryValid || secondaryValid;
        end
    end

    //////////////////////////////
    // Loop, local PPS and DAC
    localPpsGen #(
        .clkRate(clkRate)
    ) u_localPpsGen (
        .clk(clk),
        .rstN(rstN),
        .hwStrobe(hwStrobe),
        .followHw(followHw),
        .ppsStrobe(ppsStrobe)
    );

    csrRegs u_csrRegs (
        .clk(clk),
        .rstN(rstN),
        .csrStrobe(csrStrobe),
        .command(command),
        .pllEnable(pllEnable),
        .dacLoad(dacLoad),
        .dacLoadValue(dacLoadValue)
    );

    pllController #(
        .detectRange(detectRange),
        .dacCountsPerHz(dacCountsPerHz)
    ) u_pllController (
        .clk(clk),
        .rstN(rstN),
        .pllEnable(pllEnable),
        .dacLoad(dacLoad),
        .hwPpsValid(hwPpsValid),
        .hwStrobe(hwStrobe),
        .ppsStrobe(ppsStrobe),
        .dacBusy(dacBusy),
        .dacLoadValue(dacLoadValue),
        .followHw(followHw),
        .locked(locked),
        .dacStrobe(dacStrobe),
        .dacValue(dacValue),
        .phaseError(phaseError),
        .pllState(pllState)
    );

    dacSpiWriter #(
        .spiHalfTicks(spiHalfTicks)
    ) u_dacSpiWriter (
        .clk(clk),
        .rstN(rstN),
        .dacStrobe(dacStrobe),
        .offsetBinary(offsetBinary),
        .dacValue(dacValue),
        .SPI_CLK(SPI_CLK),
        .SPI_SYNCn(SPI_SYNCn),
        .SPI_SDI(SPI_SDI),
        .dacBusy(dacBusy)
    );

    // Status readback
    assign dacReadback = dacValue;

    always_comb begin
        status.locked = locked;
        status.enabled = pllEnable;
        status.hwPpsValid = hwPpsValid;
        status.primaryValid = primaryValid;
        status.secondaryValid = secondaryValid;
        status.pllState = pllState;
        status.phaseError = phaseError;
    end

endmodule

//--- tb/tbClockGen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tbClockGen #(
    parameter realtime periodNs = 40.0,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

    // Reset held for a few cycles, released away from the rising edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- tb/clockSyncTb.sv
// PPS synchronizer testbench
`timescale 1ns/100ps

module clockSyncTb;
    import syncPkg::*;
    import csrPkg::*;

    localparam realtime clkPeriod = 40.0;
    localparam int clkRate = 1000;
    localparam int dacCountsPerHz = 35;
    localparam int stepCount = 12;
    localparam int pulseWidth = 20;

    // Columns of one test step
    typedef struct packed {
        int pPer;
        int pStart;
        int pShift;
        int sPer;
        int sStart;
        int cycles;
        int cmd;
        int offBin;
        int loopErr;
        int expP;
        int expS;
        int expLock;
        int expErr;
        int follow;
        int frames;
    } step_t;

    logic clk;
    logic rstN;
    logic csrStrobe;
    logic ppsPrimary;
    logic ppsSecondary;
    logic offsetBinary;
    csrCommand_t command;
    syncStatus_t status;
    dacValue_t dacReadback;
    logic ppsStrobe;
    logic SPI_CLK;
    logic SPI_SYNCn;
    logic SPI_SDI;

    step_t steps [stepCount];
    dacValue_t loadVal [stepCount];
    int period [2];
    int countDown [2];
    int highLeft [2];
    int lastEdge [2];
    int lastLocal;
    int cycle;
    int stepErr;
    int edgeErr;
    int curErr;
    int accScaled;
    int prevErr;
    int updates;
    int valueErrors;
    int otherErrors;
    logic loopOn;
    logic [15:0] lfsrState;
    logic [23:0] shiftIn;
    int bitsIn;
    logic [23:0] frames [$];
    int frameErrs [$];

    tbClockGen #(.periodNs(clkPeriod), .resetCycles(3)) u_tbClockGen (
        .clk(clk),
        .rstN(rstN)
    );

    clockSyncTop #(
        .clkRate(clkRate),
        .debounceTicks(4),
        .toleranceTicks(4),
        .detectRange(30),
        .dacCountsPerHz(dacCountsPerHz),
        .spiHalfTicks(2)
    ) u_clockSyncTop (
        .clk(clk),
        .rstN(rstN),
        .csrStrobe(csrStrobe),
        .ppsPrimary(ppsPrimary),
        .ppsSecondary(ppsSecondary),
        .offsetBinary(offsetBinary),
        .command(command),
        .status(status),
        .dacReadback(dacReadback),
        .ppsStrobe(ppsStrobe),
        .SPI_CLK(SPI_CLK),
        .SPI_SYNCn(SPI_SYNCn),
        .SPI_SDI(SPI_SDI)
    );

    //////////////////////////////
    // Stimulus table
    task automatic loadTable();
        //              pPer pSt pSh  sPer sSt  cycles cmd ob err P S L eErr fol frm
        steps[0]  = '{0,    0,   0,   0,   0,   300,   1,  0,  0, 0, 0, 0, 0,  0,  1};
        steps[1]  = '{0,    0,   0,   0,   0,   300,   1,  1,  0, 0, 0, 0, 0,  0,  1};
        steps[2]  = '{1000, 10,  0,   0,   0,   2500,  0,  0,  0, 1, 0, 0, 0,  1,  0};
        steps[3]  = '{990,  0,   0,   0,   0,   2000,  0,  0,  0, 0, 0, 0, 0,  0,  0};
        steps[4]  = '{1000, 0,   0,   0,   0,   2500,  0,  0,  0, 1, 0, 0, 0,  1,  0};
        steps[5]  = '{0,    0,   0,   1000, 50, 2500,  0,  0,  0, 0, 1, 0, 0,  2,  0};
        steps[6]  = '{0,    0,   0,   994, 0,   2000,  0,  0,  0, 0, 0, 0, 0,  0,  0};
        steps[7]  = '{0,    0,   0,   1000, 0,  2500,  0,  0,  0, 0, 1, 0, 0,  2,  0};
        steps[8]  = '{1000, 300, 0,   1000, 0,  2500,  0,  0,  0, 1, 1, 0, 0,  1,  0};
        steps[9]  = '{1000, 0,   0,   0,   0,   1500,  0,  0,  0, 1, 0, 0, 0,  1,  0};
        steps[10] = '{1000, 0,   0,   0,   0,   22000, 2,  0,  0, 1, 0, 1, 0,  0,  1};
        steps[11] = '{1000, 0,   3,   0,   0,   3200,  0,  0, -3, 1, 0, 1, -3, 0,  1};
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randomValue(output dacValue_t v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    //////////////////////////////
    // Compare tasks
    task automatic checkStatusBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkDac(input string name, input dacValue_t got, input dacValue_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkPhase(input phaseError_t got, input phaseError_t exp);
        if (got !== exp) begin
            $display("ERR %0t: phase error is %0d, expected %0d", $time, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkState(input pllState_t got, input pllState_t exp);
        if (got !== exp) begin
            $display("ERR %0t: PLL state is %0d, expected %0d", $time, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkFrame(input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: DAC frame is %h, expected %h", $time, got, exp);
            valueErrors++;
        end
    endtask

    //////////////////////////////
    // PPS schedule stepped on each falling edge
    task automatic tickPps();
        cycle++;
        if (ppsStrobe === 1'b1) begin
            lastLocal = cycle;
        end
        for (int i = 0; i < 2; i++) begin
            if (period[i] != 0) begin
                if (countDown[i] == 0) begin
                    highLeft[i] = pulseWidth;
                    countDown[i] = period[i] - 1;
                    lastEdge[i] = cycle;
                    if (i == 0) begin
                        edgeErr = stepErr;
                    end
                end else begin
                    countDown[i]--;
                end
            end
            if (highLeft[i] > 0) begin
                highLeft[i]--;
            end
        end
        ppsPrimary = (highLeft[0] > 0);
        ppsSecondary = (highLeft[1] > 0);
    endtask

    task automatic runCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            csrStrobe = 1'b0;
            tickPps();
        end
    endtask

    // Velocity form PI model with 8 fraction bits
    task automatic modelUpdate(input int e);
        int de;
        int step256;
        de = e - prevErr;
        if (updates >= unlockCount) begin
            step256 = (de * 256) / 16 + (e * 256) / 256;
        end else begin
            step256 = (de * 256) / 2 + (e * 256) / 4;
        end
        accScaled = accScaled + step256 * dacCountsPerHz;
        if (accScaled > 32767 * 256) begin
            accScaled = 32767 * 256;
        end else if (accScaled < -32768 * 256) begin
            accScaled = -32768 * 256;
        end
        prevErr = e;
        updates++;
    endtask

    task automatic processFrames(input int idx);
        logic [23:0] got;
        dacValue_t word;
        int e;
        int seen;
        seen = 0;
        while (frames.size() > 0) begin
            got = frames.pop_front();
            e = frameErrs.pop_front();
            if (steps[idx].frames == 0) begin
                $display("Unexpected DAC frame %h in step %0d", got, idx);
                otherErrors++;
            end else begin
                if (steps[idx].cmd == 1) begin
                    word = loadVal[idx];
                    accScaled = int'(loadVal[idx]) * 256;
                end else begin
                    modelUpdate(e);
                    word = dacValue_t'(accScaled >>> 8);
                end
                if (steps[idx].offBin != 0) begin
                    word[15] = ~word[15];
                end
                checkFrame(got, {8'h00, word});
                seen++;
            end
        end
        if (steps[idx].frames != 0 && seen == 0) begin
            $display("No DAC frame seen in step %0d", idx);
            otherErrors++;
        end
    endtask

    //////////////////////////////
    // SPI monitor
    always @(negedge SPI_CLK) begin
        if (SPI_SYNCn === 1'b0) begin
            shiftIn = {shiftIn[22:0], SPI_SDI};
            bitsIn++;
        end
    end

    always @(negedge SPI_SYNCn) begin
        shiftIn = '0;
        bitsIn = 0;
        curErr = edgeErr;
    end

    always @(posedge SPI_SYNCn) begin
        if (rstN === 1'b1) begin
            if (bitsIn != 24) begin
                $display("DAC frame had %0d bits instead of 24", bitsIn);
                otherErrors++;
            end
            frames.push_back(shiftIn);
            frameErrs.push_back(curErr);
        end
    end

    // Watchdog sized from the step table
    initial begin
        int total;
        #1;
        total = 5000;
        for (int i = 0; i < stepCount; i++) begin
            total += steps[i].cycles;
        end
        #(total * clkPeriod);
        $display("Watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    initial begin
        csrStrobe = 1'b0;
        ppsPrimary = 1'b0;
        ppsSecondary = 1'b0;
        offsetBinary = 1'b0;
        command = '0;
        lfsrState = 16'd71;
        cycle = 0;
        lastLocal = 0;
        stepErr = 0;
        edgeErr = 0;
        curErr = 0;
        accScaled = 0;
        prevErr = 0;
        updates = 0;
        valueErrors = 0;
        otherErrors = 0;
        loopOn = 1'b0;
        shiftIn = '0;
        bitsIn = 0;
        for (int i = 0; i < 2; i++) begin
            period[i] = 0;
            countDown[i] = 0;
            highLeft[i] = 0;
            lastEdge[i] = 0;
        end
        loadTable();
        @(posedge rstN);

        for (int idx = 0; idx < stepCount; idx++) begin
            @(negedge clk);
            if (period[0] == 0) begin
                countDown[0] = steps[idx].pStart;
            end
            if (period[1] == 0) begin
                countDown[1] = steps[idx].sStart;
            end
            period[0] = steps[idx].pPer;
            period[1] = steps[idx].sPer;
            countDown[0] += steps[idx].pShift;
            stepErr = steps[idx].loopErr;
            offsetBinary = (steps[idx].offBin != 0);
            command = '0;
            if (steps[idx].cmd == 1) begin
                randomValue(loadVal[idx]);
                command.dacLoad = 1'b1;
                command.dacValue = loadVal[idx];
            end else if (steps[idx].cmd == 2) begin
                command.pllEnable = 1'b1;
                prevErr = 0;
                updates = 0;
                loopOn = 1'b1;
            end
            csrStrobe = (steps[idx].cmd != 0);
            tickPps();
            runCycles(steps[idx].cycles - 1);
            while (SPI_SYNCn !== 1'b1) begin
                runCycles(1);
            end

            checkStatusBit("primaryValid", status.primaryValid, steps[idx].expP != 0);
            checkStatusBit("secondaryValid", status.secondaryValid, steps[idx].expS != 0);
            checkStatusBit("hwPpsValid", status.hwPpsValid,
                steps[idx].expP != 0 || steps[idx].expS != 0);
            checkStatusBit("enabled", status.enabled, loopOn);
            checkStatusBit("locked", status.locked, steps[idx].expLock != 0);
            checkPhase(status.phaseError, phaseError_t'(steps[idx].expErr));
            if (loopOn) begin
                if (status.pllState == initialize) begin
                    $display("Loop dropped back to its initial state in step %0d", idx);
                    otherErrors++;
                end
            end else begin
                checkState(status.pllState, initialize);
            end
            if (steps[idx].cmd == 1) begin
                checkDac("dacReadback", dacReadback, loadVal[idx]);
            end
            if (steps[idx].follow != 0 && lastLocal - lastEdge[steps[idx].follow - 1] != 4) begin
                $display("Local PPS in step %0d did not follow the selected input", idx);
                otherErrors++;
            end
            processFrames(idx);
        end

        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/syncPkg.sv
src/csrPkg.sv
src/ppsQualifier.sv
src/localPpsGen.sv
src/csrRegs.sv
src/pllController.sv
src/dacSpiWriter.sv
src/clockSyncTop.sv
tb/tbClockGen.sv
tb/clockSyncTb.sv

//--- Makefile
# Verilator build for the PPS synchronizer testbench

VERILATOR ?= verilator
TOP ?= clockSyncTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
